// ==== logic/spm_pkg.sv ====
// Shared sizes of the tile scratchpad
// Bank remap shift width and the word address union

package spm_pkg;

  // Bank geometry
  localparam int unsigned NumBanks = 4;
  localparam int unsigned BankIdxW = $clog2(NumBanks);
  localparam int unsigned NumRows  = 16;
  localparam int unsigned RowIdxW  = $clog2(NumRows);

  // Flat word address covers every row of every bank
  localparam int unsigned AddrW = RowIdxW + BankIdxW;
  localparam int unsigned DataW = 32;

  // Row bits folded into the bank index, limited by the narrower field
  localparam int unsigned ShiftW = (RowIdxW < BankIdxW) ? RowIdxW : BankIdxW;

  // Word address as seen on the bus, or split into row and bank.
  // Bank sits in the low bits so consecutive words hit consecutive banks
  typedef union packed {
    logic [AddrW-1:0] word;
    struct packed {
      logic [RowIdxW-1:0]  row;
      logic [BankIdxW-1:0] bank;
    } fields;
  } spm_addr_u;

endpackage

// ==== logic/bank_id_remapper.sv ====
// Bank index remapper
// Rotates the logical bank by the low row bits so strided traffic spreads out

`timescale 1ns/1ns

module bank_id_remapper (
  input  spm_pkg::spm_addr_u             wb_adr_i,
  output logic [spm_pkg::BankIdxW-1:0]   bank_o,
  output logic [spm_pkg::RowIdxW-1:0]    row_o
);
  import spm_pkg::*;

  logic [BankIdxW-1:0] log_bank;
  logic [RowIdxW-1:0]  log_row;
  logic [ShiftW-1:0]   row_low;
  logic [BankIdxW-1:0] rot_amt;

  // Split the word address into its row and bank fields
  assign log_bank = wb_adr_i.fields.bank;
  assign log_row  = wb_adr_i.fields.row;

  // Low row bits pick the rotation
  assign row_low = log_row[ShiftW-1:0];

  always_comb begin
    rot_amt = '0;
    rot_amt[ShiftW-1:0] = row_low;
  end

  // Sum wraps at NumBanks since the bank index is a power of two wide
  assign bank_o = log_bank + rot_amt;

  // Row is not touched, so the mapping stays a bijection
  assign row_o = log_row;

endmodule

// ==== logic/wb_tcdm_port.sv ====
// Wishbone classic slave port onto the bank array
// Holds a request until granted, then acks with read data

`timescale 1ns/1ns

module wb_tcdm_port (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // Wishbone slave side
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  spm_pkg::spm_addr_u           wb_adr_i,
  input  logic [spm_pkg::DataW-1:0]    wb_dat_i,
  output logic [spm_pkg::DataW-1:0]    wb_dat_o,
  output logic                         wb_ack_o,
  // Request side towards the bank array
  output logic                         req_o,
  output logic                         req_we_o,
  output logic [spm_pkg::BankIdxW-1:0] req_bank_o,
  output logic [spm_pkg::RowIdxW-1:0]  req_row_o,
  output logic [spm_pkg::DataW-1:0]    req_wdata_o,
  input  logic                         gnt_i,
  input  logic [spm_pkg::DataW-1:0]    rdata_i
);
  import spm_pkg::*;

  // Controller state, low is idle and high is acknowledging
  logic                ack_q;
  logic [BankIdxW-1:0] phys_bank;
  logic [RowIdxW-1:0]  phys_row;

  bank_id_remapper u_remap (
    .wb_adr_i (wb_adr_i),
    .bank_o   (phys_bank),
    .row_o    (phys_row)
  );

  // Request stays up while the master holds cyc and stb.
  // Stb is ignored in the ack cycle so one access never issues twice
  assign req_o       = wb_cyc_i && wb_stb_i && !ack_q;
  assign req_we_o    = wb_we_i;
  assign req_bank_o  = phys_bank;
  assign req_row_o   = phys_row;
  assign req_wdata_o = wb_dat_i;

  // Grant moves to acknowledging for exactly one cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else if (ack_q) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_o && gnt_i;
    end
  end

  assign wb_ack_o = ack_q;

  // Bank array registers read data in the grant cycle,
  // so it lines up with the ack
  assign wb_dat_o = ack_q ? rdata_i : '0;

endmodule

// ==== logic/spm_bank_array.sv ====
// Four banks of scratchpad storage shared by two ports
// Per-bank collision resolution with alternating priority

`timescale 1ns/1ns

module spm_bank_array (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // Local port request
  input  logic                         loc_req_i,
  input  logic                         loc_we_i,
  input  logic [spm_pkg::BankIdxW-1:0] loc_bank_i,
  input  logic [spm_pkg::RowIdxW-1:0]  loc_row_i,
  input  logic [spm_pkg::DataW-1:0]    loc_wdata_i,
  // Remote port request
  input  logic                         rmt_req_i,
  input  logic                         rmt_we_i,
  input  logic [spm_pkg::BankIdxW-1:0] rmt_bank_i,
  input  logic [spm_pkg::RowIdxW-1:0]  rmt_row_i,
  input  logic [spm_pkg::DataW-1:0]    rmt_wdata_i,
  // Grants and registered read data
  output logic                         loc_gnt_o,
  output logic                         rmt_gnt_o,
  output logic [spm_pkg::DataW-1:0]    loc_rdata_o,
  output logic [spm_pkg::DataW-1:0]    rmt_rdata_o
);
  import spm_pkg::*;

  logic [NumBanks-1:0] loc_gnt_bank;
  logic [NumBanks-1:0] rmt_gnt_bank;
  logic [DataW-1:0]    bank_rdata [NumBanks];
  logic [DataW-1:0]    loc_rdata_q;
  logic [DataW-1:0]    rmt_rdata_q;

  for (genvar b = 0; b < NumBanks; b++) begin : g_bank
    logic               loc_hit;
    logic               rmt_hit;
    // Low favours the local port
    logic               prio_q;
    logic [RowIdxW-1:0] rd_row;
    logic [DataW-1:0]   mem_q [NumRows];

    assign loc_hit = loc_req_i && (loc_bank_i == BankIdxW'(b));
    assign rmt_hit = rmt_req_i && (rmt_bank_i == BankIdxW'(b));

    // Lone requester always wins, a shared bank goes by priority
    assign loc_gnt_bank[b] = loc_hit && (!rmt_hit || !prio_q);
    assign rmt_gnt_bank[b] = rmt_hit && (!loc_hit || prio_q);

    // Flip after every collision so the loser wins next time
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        prio_q <= 1'b0;
      end else if (loc_hit && rmt_hit) begin
        prio_q <= ~prio_q;
      end
    end

    // At most one port owns the bank in a cycle
    always_ff @(posedge clk_i) begin
      if (loc_gnt_bank[b] && loc_we_i) begin
        mem_q[loc_row_i] <= loc_wdata_i;
      end else if (rmt_gnt_bank[b] && rmt_we_i) begin
        mem_q[rmt_row_i] <= rmt_wdata_i;
      end
    end

    // Read row follows whichever port holds the bank
    assign rd_row        = loc_gnt_bank[b] ? loc_row_i : rmt_row_i;
    assign bank_rdata[b] = mem_q[rd_row];
  end

  assign loc_gnt_o = |loc_gnt_bank;
  assign rmt_gnt_o = |rmt_gnt_bank;

  // Read data lands one cycle after the grant
  always_ff @(posedge clk_i) begin
    if (loc_gnt_o && !loc_we_i) begin
      loc_rdata_q <= bank_rdata[loc_bank_i];
    end
    if (rmt_gnt_o && !rmt_we_i) begin
      rmt_rdata_q <= bank_rdata[rmt_bank_i];
    end
  end

  assign loc_rdata_o = loc_rdata_q;
  assign rmt_rdata_o = rmt_rdata_q;

endmodule

// ==== logic/spm_tile_top.sv ====
// Tile scratchpad top level
// Local and remote Wishbone ports sharing one bank array

`timescale 1ns/1ns

module spm_tile_top (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // Local core port
  input  logic                      loc_wb_cyc_i,
  input  logic                      loc_wb_stb_i,
  input  logic                      loc_wb_we_i,
  input  spm_pkg::spm_addr_u        loc_wb_adr_i,
  input  logic [spm_pkg::DataW-1:0] loc_wb_dat_i,
  output logic [spm_pkg::DataW-1:0] loc_wb_dat_o,
  output logic                      loc_wb_ack_o,
  // Remote port
  input  logic                      rmt_wb_cyc_i,
  input  logic                      rmt_wb_stb_i,
  input  logic                      rmt_wb_we_i,
  input  spm_pkg::spm_addr_u        rmt_wb_adr_i,
  input  logic [spm_pkg::DataW-1:0] rmt_wb_dat_i,
  output logic [spm_pkg::DataW-1:0] rmt_wb_dat_o,
  output logic                      rmt_wb_ack_o
);
  import spm_pkg::*;

  // Local request path
  logic                loc_req;
  logic                loc_we;
  logic [BankIdxW-1:0] loc_bank;
  logic [RowIdxW-1:0]  loc_row;
  logic [DataW-1:0]    loc_wdata;
  logic                loc_gnt;
  logic [DataW-1:0]    loc_rdata;

  // Remote request path
  logic                rmt_req;
  logic                rmt_we;
  logic [BankIdxW-1:0] rmt_bank;
  logic [RowIdxW-1:0]  rmt_row;
  logic [DataW-1:0]    rmt_wdata;
  logic                rmt_gnt;
  logic [DataW-1:0]    rmt_rdata;

  wb_tcdm_port u_loc_port (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wb_cyc_i    (loc_wb_cyc_i),
    .wb_stb_i    (loc_wb_stb_i),
    .wb_we_i     (loc_wb_we_i),
    .wb_adr_i    (loc_wb_adr_i),
    .wb_dat_i    (loc_wb_dat_i),
    .wb_dat_o    (loc_wb_dat_o),
    .wb_ack_o    (loc_wb_ack_o),
    .req_o       (loc_req),
    .req_we_o    (loc_we),
    .req_bank_o  (loc_bank),
    .req_row_o   (loc_row),
    .req_wdata_o (loc_wdata),
    .gnt_i       (loc_gnt),
    .rdata_i     (loc_rdata)
  );

  wb_tcdm_port u_rmt_port (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wb_cyc_i    (rmt_wb_cyc_i),
    .wb_stb_i    (rmt_wb_stb_i),
    .wb_we_i     (rmt_wb_we_i),
    .wb_adr_i    (rmt_wb_adr_i),
    .wb_dat_i    (rmt_wb_dat_i),
    .wb_dat_o    (rmt_wb_dat_o),
    .wb_ack_o    (rmt_wb_ack_o),
    .req_o       (rmt_req),
    .req_we_o    (rmt_we),
    .req_bank_o  (rmt_bank),
    .req_row_o   (rmt_row),
    .req_wdata_o (rmt_wdata),
    .gnt_i       (rmt_gnt),
    .rdata_i     (rmt_rdata)
  );

  spm_bank_array u_bank_array (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .loc_req_i   (loc_req),
    .loc_we_i    (loc_we),
    .loc_bank_i  (loc_bank),
    .loc_row_i   (loc_row),
    .loc_wdata_i (loc_wdata),
    .rmt_req_i   (rmt_req),
    .rmt_we_i    (rmt_we),
    .rmt_bank_i  (rmt_bank),
    .rmt_row_i   (rmt_row),
    .rmt_wdata_i (rmt_wdata),
    .loc_gnt_o   (loc_gnt),
    .rmt_gnt_o   (rmt_gnt),
    .loc_rdata_o (loc_rdata),
    .rmt_rdata_o (rmt_rdata)
  );

endmodule

// ==== sim/tb_spm_tile.sv ====
// Testbench for the tile scratchpad
// Bus tasks, reference memory with bank priority model, LFSR stimulus and assertions

`timescale 1ns/1ns

module tb_spm_tile;
  import spm_pkg::*;

  localparam int ClkPeriod   = 4;
  localparam int ResetCycles = 10;
  localparam int NumWords    = NumBanks * NumRows;
  localparam int NumRand     = 48;
  // Fill, cross readback, six bank collisions, two remap pairs, random run
  localparam int NumAccesses = 2 * NumWords + 8 + NumRand;

  logic             clk_i;
  logic             rst_i;
  logic             loc_cyc;
  logic             loc_stb;
  logic             loc_we;
  spm_addr_u        loc_adr;
  logic [DataW-1:0] loc_dat;
  logic [DataW-1:0] loc_dat_out;
  logic             loc_ack;
  logic             rmt_cyc;
  logic             rmt_stb;
  logic             rmt_we;
  spm_addr_u        rmt_adr;
  logic [DataW-1:0] rmt_dat;
  logic [DataW-1:0] rmt_dat_out;
  logic             rmt_ack;

  // Expected responses, updated on the falling edge
  logic             exp_loc_ack;
  logic             exp_loc_rd;
  logic [DataW-1:0] exp_loc_dat;
  logic             exp_rmt_ack;
  logic             exp_rmt_rd;
  logic [DataW-1:0] exp_rmt_dat;

  logic [DataW-1:0] ref_mem [NumWords];
  // Low favours the local port
  logic             prio_model [NumBanks];
  logic [31:0]      lfsr = 32'h0f43_9ee2;

  spm_tile_top uut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .loc_wb_cyc_i (loc_cyc),
    .loc_wb_stb_i (loc_stb),
    .loc_wb_we_i  (loc_we),
    .loc_wb_adr_i (loc_adr),
    .loc_wb_dat_i (loc_dat),
    .loc_wb_dat_o (loc_dat_out),
    .loc_wb_ack_o (loc_ack),
    .rmt_wb_cyc_i (rmt_cyc),
    .rmt_wb_stb_i (rmt_stb),
    .rmt_wb_we_i  (rmt_we),
    .rmt_wb_adr_i (rmt_adr),
    .rmt_wb_dat_i (rmt_dat),
    .rmt_wb_dat_o (rmt_dat_out),
    .rmt_wb_ack_o (rmt_ack)
  );

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("error at %0t ns: %s expected %h, got %h", $time, sig, exp_val, act_val);
    $display("Regression failed");
    $fatal(1);
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd000_0001) : (lfsr >> 1);
    end
    return r;
  endfunction

  // Logical bank plus the low row bits, wrapping at NumBanks
  function automatic logic [BankIdxW-1:0] phys_bank(input logic [AddrW-1:0] word);
    spm_addr_u a;
    a.word = word;
    return a.fields.bank + a.fields.row[ShiftW-1:0];
  endfunction

  function automatic logic [DataW-1:0] mem_access(input logic we, input logic [AddrW-1:0] adr,
                                                  input logic [DataW-1:0] dat);
    if (we) begin
      ref_mem[adr] = dat;
    end
    return ref_mem[adr];
  endfunction

  // One access per enabled port, issued together, entered and left on a falling edge
  task automatic access(input logic do_loc, input logic l_we, input logic [AddrW-1:0] l_adr,
                        input logic [DataW-1:0] l_dat, input logic do_rmt, input logic r_we,
                        input logic [AddrW-1:0] r_adr, input logic [DataW-1:0] r_dat);
    logic [BankIdxW-1:0] l_pb;
    logic [BankIdxW-1:0] r_pb;
    int                  l_delay;
    int                  r_delay;
    logic [DataW-1:0]    l_exp;
    logic [DataW-1:0]    r_exp;
    l_pb    = phys_bank(l_adr);
    r_pb    = phys_bank(r_adr);
    l_delay = 1;
    r_delay = 1;
    l_exp   = '0;
    r_exp   = '0;
    // Same physical bank, the priority bit picks the winner and then flips
    if (do_loc && do_rmt && (l_pb == r_pb)) begin
      if (prio_model[l_pb]) begin
        l_delay = 2;
      end else begin
        r_delay = 2;
      end
      prio_model[l_pb] = !prio_model[l_pb];
    end
    // Reference memory sees the accesses in grant order
    for (int step = 1; step <= 2; step++) begin
      if (do_loc && (l_delay == step)) begin
        l_exp = mem_access(l_we, l_adr, l_dat);
      end
      if (do_rmt && (r_delay == step)) begin
        r_exp = mem_access(r_we, r_adr, r_dat);
      end
    end
    loc_cyc      = do_loc;
    loc_stb      = do_loc;
    loc_we       = l_we;
    loc_adr.word = l_adr;
    loc_dat      = l_dat;
    rmt_cyc      = do_rmt;
    rmt_stb      = do_rmt;
    rmt_we       = r_we;
    rmt_adr.word = r_adr;
    rmt_dat      = r_dat;
    exp_loc_ack  = 1'b0;
    exp_rmt_ack  = 1'b0;
    for (int step = 1; step <= 3; step++) begin
      @(negedge clk_i);
      exp_loc_ack = do_loc && (l_delay == step);
      exp_loc_rd  = !l_we;
      exp_loc_dat = l_exp;
      exp_rmt_ack = do_rmt && (r_delay == step);
      exp_rmt_rd  = !r_we;
      exp_rmt_dat = r_exp;
      // Master drops its strobe once it sees ack
      if (loc_ack || (step == 3)) begin
        loc_cyc = 1'b0;
        loc_stb = 1'b0;
      end
      if (rmt_ack || (step == 3)) begin
        rmt_cyc = 1'b0;
        rmt_stb = 1'b0;
      end
    end
  endtask

  loc_ack_chk: assert property (@(posedge clk_i) disable iff (rst_i) loc_ack == exp_loc_ack)
    else report_mismatch("loc_wb_ack_o", 32'(exp_loc_ack), 32'($sampled(loc_ack)));
  rmt_ack_chk: assert property (@(posedge clk_i) disable iff (rst_i) rmt_ack == exp_rmt_ack)
    else report_mismatch("rmt_wb_ack_o", 32'(exp_rmt_ack), 32'($sampled(rmt_ack)));
  loc_dat_chk: assert property (@(posedge clk_i) disable iff (rst_i)
                                !(exp_loc_ack && exp_loc_rd) || (loc_dat_out == exp_loc_dat))
    else report_mismatch("loc_wb_dat_o", exp_loc_dat, $sampled(loc_dat_out));
  rmt_dat_chk: assert property (@(posedge clk_i) disable iff (rst_i)
                                !(exp_rmt_ack && exp_rmt_rd) || (rmt_dat_out == exp_rmt_dat))
    else report_mismatch("rmt_wb_dat_o", exp_rmt_dat, $sampled(rmt_dat_out));

  initial begin
    #(NumAccesses * 4 * ClkPeriod + ResetCycles * ClkPeriod);
    $display("error: watchdog expired before the test sequence completed");
    $display("Regression failed");
    $fatal(1);
  end

  initial begin
    logic [1:0]       sel;
    logic [DataW-1:0] d0;
    logic [DataW-1:0] d1;
    rst_i        = 1'b1;
    loc_cyc      = 1'b0;
    loc_stb      = 1'b0;
    loc_we       = 1'b0;
    loc_adr.word = '0;
    loc_dat      = '0;
    rmt_cyc      = 1'b0;
    rmt_stb      = 1'b0;
    rmt_we       = 1'b0;
    rmt_adr.word = '0;
    rmt_dat      = '0;
    exp_loc_ack  = 1'b0;
    exp_loc_rd   = 1'b0;
    exp_loc_dat  = '0;
    exp_rmt_ack  = 1'b0;
    exp_rmt_rd   = 1'b0;
    exp_rmt_dat  = '0;
    for (int b = 0; b < NumBanks; b++) begin
      prio_model[b] = 1'b0;
    end
    repeat (ResetCycles) @(negedge clk_i);
    rst_i = 1'b0;
    // Idle bus after reset, acks must stay low
    repeat (5) @(negedge clk_i);

    // Fill every word, alternating ports, then read back through the other port
    for (int w = 0; w < NumWords; w++) begin
      d0 = DataW'(rand_bits(DataW));
      access((w % 2) == 0, 1'b1, AddrW'(w), d0, (w % 2) == 1, 1'b1, AddrW'(w), d0);
    end
    for (int w = 0; w < NumWords; w++) begin
      access((w % 2) == 1, 1'b0, AddrW'(w), '0, (w % 2) == 0, 1'b0, AddrW'(w), '0);
    end

    // Words 2 and 8 share physical bank 2, winner alternates.
    // An odd count leaves bank 2 favouring the remote port
    for (int r = 0; r < 5; r++) begin
      d0 = DataW'(rand_bits(DataW));
      d1 = DataW'(rand_bits(DataW));
      access(1'b1, r[0], AddrW'(2), d0, 1'b1, r[1], AddrW'(8), d1);
    end
    // Bank 3 still starts with the local port
    access(1'b1, 1'b0, AddrW'(3), '0, 1'b1, 1'b0, AddrW'(12), '0);

    // Different logical banks on one physical bank, then the reverse
    access(1'b1, 1'b0, AddrW'(1), '0, 1'b1, 1'b0, AddrW'(4), '0);
    access(1'b1, 1'b0, AddrW'(0), '0, 1'b1, 1'b0, AddrW'(4), '0);

    for (int i = 0; i < NumRand; i++) begin
      sel = 2'(rand_bits(2));
      if (sel == 2'b00) begin
        sel = 2'b11;
      end
      d0 = DataW'(rand_bits(DataW));
      d1 = DataW'(rand_bits(DataW));
      access(sel[0], 1'(rand_bits(1)), AddrW'(rand_bits(AddrW)), d0,
             sel[1], 1'(rand_bits(1)), AddrW'(rand_bits(AddrW)), d1);
    end

    repeat (4) @(negedge clk_i);
    $display("Regression passed");
    $finish;
  end

endmodule

// ==== flist.f ====
logic/spm_pkg.sv
logic/bank_id_remapper.sv
logic/wb_tcdm_port.sv
logic/spm_bank_array.sv
logic/spm_tile_top.sv
sim/tb_spm_tile.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_spm_tile
FLIST     := flist.f
MDIR      := obj_dir
LOG       := sim.log
LINTFLAGS := --lint-only --timing --assert
SIMFLAGS  := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(MDIR)
	-./$(MDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)
